// ==== flist.f ====
+incdir+src
src/dcache_pkg.sv
src/dcache_load_align.sv
src/dcache_line_store.sv
src/dcache_tag_store.sv
src/dcache_ctrl.sv
src/dcache_top.sv
sim/dcache_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module dcache_tb -f flist.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/Vdcache_tb > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "tests failed" sim.log; then
    exit 1
fi
exit 0

// ==== sim/dcache_stimulus.txt ====
# name op addr dtype wdata exp_load exp_wb (numbers in hex)
# exp_load is ignored for stores, exp_wb is the first write-back beat address or none
cold_ld_w   load  0040 word   00000000 0040ffbf none
hit_ld_w    load  0044 word   00000000 0044ffbb none
ld_b0_s     load  0048 byte   00000000 ffffffb7 none
ld_b0_u     load  0048 byte_u 00000000 000000b7 none
ld_b1_s     load  0049 byte   00000000 ffffffff none
ld_b2_s     load  004a byte   00000000 00000048 none
ld_h0_s     load  0048 half   00000000 ffffffb7 none
ld_h0_u     load  0048 half_u 00000000 0000ffb7 none
ld_h1_s     load  004a half   00000000 00000048 none
ld_beat3_w  load  007c word   00000000 007cff83 none
st_b1       store 0051 byte   000000a5 00000000 none
ld_st_w     load  0050 word   00000000 0050a5af none
ld_st_b1    load  0051 byte   00000000 ffffffa5 none
ld_nb_b0u   load  0050 byte_u 00000000 000000af none
st_h1       store 0056 half   00008001 00000000 none
ld_st_h1    load  0056 half   00000000 ffff8001 none
ld_nb_h0u   load  0054 half_u 00000000 0000ffab none
st_w        store 0058 word   cafef00d 00000000 none
ld_st_w2    load  0058 word   00000000 cafef00d none
st_miss_w   store 0240 word   deadbeef 00000000 none
ld_stmiss   load  0240 word   00000000 deadbeef none
ld_stmiss_n load  0244 word   00000000 0244fdbb none
evict_ld    load  0440 word   00000000 0440fbbf 004
wb_round_w  load  0050 word   00000000 0050a5af 024
wb_round_h  load  0056 half   00000000 ffff8001 none
wb_round_w2 load  0058 word   00000000 cafef00d none
clean_ev_1  load  0240 word   00000000 deadbeef none
clean_ev_2  load  0440 word   00000000 0440fbbf none
st_miss_b3  store 0003 byte   0000007f 00000000 none
ld_set0_w   load  0000 word   00000000 7f00ffff none
ld_set0_b3  load  0003 byte   00000000 0000007f none

// ==== sim/dcache_tb.sv ====
`timescale 1ns/1ps

module dcache_tb;
    import dcache_pkg::*;

    localparam int MAX_TESTS   = 64;
    localparam int MEM_BEATS   = 4096;
    localparam int CLK_NS      = 100;
    localparam int TEST_CYCLES = 30;

    logic      clk;
    logic      rst;
    logic      req_valid;
    logic      req_write;
    addr_t     req_addr;
    dtype_t    req_dtype;
    word_t     req_wdata;
    logic      req_ready;
    logic      rsp_valid;
    word_t     rsp_data;
    logic      mem_rd_valid;
    blk_addr_t mem_rd_addr;
    logic      mem_rsp_valid;
    beat_t     mem_rsp_data;
    logic      mem_wr_valid;
    blk_addr_t mem_wr_addr;
    beat_t     mem_wr_data;

    // one row of the stimulus file per entry
    string     t_name   [MAX_TESTS];
    logic      t_store  [MAX_TESTS];
    addr_t     t_addr   [MAX_TESTS];
    dtype_t    t_dtype  [MAX_TESTS];
    word_t     t_wdata  [MAX_TESTS];
    word_t     t_exp    [MAX_TESTS];
    logic      t_has_wb [MAX_TESTS];
    blk_addr_t t_wb     [MAX_TESTS];
    int        n_tests = 0;
    logic      loaded  = 1'b0;

    // memory model with its queue of read answers in issue order
    beat_t       mem [MEM_BEATS];
    blk_addr_t   rd_addr_q [$];
    int          rd_due_q [$];
    int          rd_due;
    int          last_due  = 0;
    logic [31:0] lcg_state = 32'd30727;
    int          cyc       = 0;
    logic        prev_rst  = 1'b1;

    // resident tags of each set, most recently used first
    logic [6:0] mru_tag [8];
    logic [6:0] lru_tag [8];
    logic [7:0] mru_ok = '0;
    logic [7:0] lru_ok = '0;

    // what the bus monitor saw during the current access
    int        n_rd = 0;
    int        n_wr = 0;
    blk_addr_t rd_seen [4];
    blk_addr_t wr_seen [4];
    logic      load_pending = 1'b0;
    logic      rsp_seen = 1'b0;
    word_t     rsp_word;
    int        rsp_cyc;
    int        acc_cyc;

    dcache_top dcache_top_i (
        .clk, .rst,
        .req_valid, .req_write, .req_addr, .req_dtype, .req_wdata,
        .req_ready, .rsp_valid, .rsp_data,
        .mem_rd_valid, .mem_rd_addr,
        .mem_rsp_valid, .mem_rsp_data,
        .mem_wr_valid, .mem_wr_addr, .mem_wr_data
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string test, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            abort_run($sformatf("MISMATCH %s expected %h actual %h", test, exp, act));
        end
    endtask

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    // two-way LRU keeps the last two distinct tags of a set
    function automatic logic predict_hit(input addr_t a);
        logic [2:0] s;
        logic [6:0] t;
        logic       in_mru;
        logic       in_lru;
        s      = a[8:6];
        t      = a[15:9];
        in_mru = mru_ok[s] && mru_tag[s] == t;
        in_lru = lru_ok[s] && lru_tag[s] == t;
        if (!in_mru) begin
            lru_tag[s] = mru_tag[s];
            lru_ok[s]  = mru_ok[s];
            mru_tag[s] = t;
            mru_ok[s]  = 1'b1;
        end
        return in_mru || in_lru;
    endfunction

    // every word holds its own byte address on top and the inverse below
    task automatic fill_memory();
        logic [15:0] a;
        for (int b = 0; b < MEM_BEATS; b++) begin
            for (int k = 0; k < 4; k++) begin
                a = 16'(b * 16 + k * 4);
                mem[b][k * 32 +: 32] = {a, ~a};
            end
        end
    endtask

    task automatic read_stimulus();
        int           fd;
        int           got;
        string        line;
        logic [127:0] name_v;
        logic [63:0]  op_v;
        logic [63:0]  dt_v;
        logic [63:0]  wb_v;
        logic [15:0]  addr_v;
        logic [31:0]  wdata_v;
        logic [31:0]  exp_v;
        logic [11:0]  wb_addr_v;
        fd = $fopen("sim/dcache_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open the stimulus file sim/dcache_stimulus.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            got = $fgets(line, fd);
            if (got > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
                got = $sscanf(line, "%s %s %h %s %h %h %s",
                              name_v, op_v, addr_v, dt_v, wdata_v, exp_v, wb_v);
                if (got != 7) begin
                    abort_run($sformatf("malformed stimulus line: %s", line));
                end
                if (n_tests >= MAX_TESTS) begin
                    abort_run("stimulus file holds more tests than the table can keep");
                end
                t_name[n_tests]  = $sformatf("%0s", name_v);
                t_addr[n_tests]  = addr_v;
                t_wdata[n_tests] = wdata_v;
                t_exp[n_tests]   = exp_v;
                if (op_v == "store") begin
                    t_store[n_tests] = 1'b1;
                end else if (op_v == "load") begin
                    t_store[n_tests] = 1'b0;
                end else begin
                    abort_run($sformatf("unknown operation in stimulus line: %s", line));
                end
                if (dt_v == "byte") begin
                    t_dtype[n_tests] = dt_byte;
                end else if (dt_v == "half") begin
                    t_dtype[n_tests] = dt_half;
                end else if (dt_v == "word") begin
                    t_dtype[n_tests] = dt_word;
                end else if (dt_v == "byte_u") begin
                    t_dtype[n_tests] = dt_byte_u;
                end else if (dt_v == "half_u") begin
                    t_dtype[n_tests] = dt_half_u;
                end else begin
                    abort_run($sformatf("unknown access size in stimulus line: %s", line));
                end
                if (wb_v == "none") begin
                    t_has_wb[n_tests] = 1'b0;
                    t_wb[n_tests]     = '0;
                end else begin
                    got = $sscanf(line, "%s %s %h %s %h %h %h",
                                  name_v, op_v, addr_v, dt_v, wdata_v, exp_v, wb_addr_v);
                    if (got != 7) begin
                        abort_run($sformatf("bad write-back address in stimulus line: %s",
                                            line));
                    end
                    t_has_wb[n_tests] = 1'b1;
                    t_wb[n_tests]     = wb_addr_v;
                end
                n_tests++;
            end
        end
        $fclose(fd);
        if (n_tests == 0) begin
            abort_run("stimulus file holds no tests");
        end
    endtask

    // one request, then its response or completion, then the bus checks
    task automatic run_access(input int i);
        string name;
        logic  exp_hit;
        name    = t_name[i];
        exp_hit = predict_hit(t_addr[i]);
        @(posedge clk);
        #1;
        n_rd         = 0;
        n_wr         = 0;
        rsp_seen     = 1'b0;
        load_pending = !t_store[i];
        req_valid    = 1'b1;
        req_write    = t_store[i];
        req_addr     = t_addr[i];
        req_dtype    = t_dtype[i];
        req_wdata    = t_wdata[i];
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        acc_cyc = cyc;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        if (t_store[i]) begin
            @(negedge clk);
            while (!req_ready) begin
                @(negedge clk);
            end
        end else begin
            while (!rsp_seen) begin
                @(posedge clk);
            end
            check_value({name, " load data"}, t_exp[i], rsp_word);
        end
        if (t_has_wb[i]) begin
            check_value({name, " write-back beats"}, 32'd4, 32'(n_wr));
            for (int b = 0; b < 4; b++) begin
                check_value({name, " write-back address"}, 32'(t_wb[i]) + 32'(b),
                            32'(wr_seen[b]));
            end
        end else begin
            check_value({name, " write-back beats"}, 32'd0, 32'(n_wr));
        end
        if (exp_hit) begin
            check_value({name, " refill beats"}, 32'd0, 32'(n_rd));
            if (!t_store[i]) begin
                check_value({name, " hit latency"}, 32'd1, 32'(rsp_cyc - acc_cyc));
            end
        end else begin
            check_value({name, " refill beats"}, 32'd4, 32'(n_rd));
            for (int b = 0; b < 4; b++) begin
                check_value({name, " refill address"}, 32'({t_addr[i][15:6], 2'(b)}),
                            32'(rd_seen[b]));
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_NS / 2) clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // answers leave in order, 1 to 3 cycles after their read strobe
    always @(posedge clk) begin
        #1;
        if (rd_due_q.size() > 0 && rd_due_q[0] <= cyc) begin
            mem_rsp_valid = 1'b1;
            mem_rsp_data  = mem[rd_addr_q[0]];
            void'(rd_due_q.pop_front());
            void'(rd_addr_q.pop_front());
        end else begin
            mem_rsp_valid = 1'b0;
        end
    end

    // outputs are sampled mid-cycle where they are settled
    always @(negedge clk) begin
        if (rst || prev_rst) begin
            check_value("reset req_ready", 32'd0, 32'(req_ready));
            check_value("reset rsp_valid", 32'd0, 32'(rsp_valid));
            check_value("reset mem_rd_valid", 32'd0, 32'(mem_rd_valid));
            check_value("reset mem_wr_valid", 32'd0, 32'(mem_wr_valid));
        end
        prev_rst = rst;
        if (!rst) begin
            if (mem_wr_valid) begin
                if (n_rd > 0) begin
                    abort_run("write-back strobe seen after a read strobe of the same miss");
                end
                if (n_wr >= 4) begin
                    abort_run("more than four write-back strobes in one access");
                end
                mem[mem_wr_addr] = mem_wr_data;
                wr_seen[n_wr]    = mem_wr_addr;
                n_wr++;
            end
            if (mem_rd_valid) begin
                if (n_rd >= 4) begin
                    abort_run("more than four read strobes in one access");
                end
                rd_seen[n_rd] = mem_rd_addr;
                n_rd++;
                rd_due = cyc + 1 + int'(next_rand() % 32'd3);
                if (rd_due <= last_due) begin
                    rd_due = last_due + 1;
                end
                last_due = rd_due;
                rd_addr_q.push_back(mem_rd_addr);
                rd_due_q.push_back(rd_due);
            end
            if (rsp_valid) begin
                if (!load_pending) begin
                    abort_run("load response strobe while no load was outstanding");
                end
                load_pending = 1'b0;
                rsp_seen     = 1'b1;
                rsp_word     = rsp_data;
                rsp_cyc      = cyc;
            end
        end
    end

    initial begin
        wait (loaded);
        #((n_tests * TEST_CYCLES + 20) * CLK_NS);
        abort_run("watchdog timeout, the tests did not finish in time");
    end

    initial begin
        rst           = 1'b1;
        req_valid     = 1'b0;
        req_write     = 1'b0;
        req_addr      = '0;
        req_dtype     = dt_word;
        req_wdata     = '0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;
        fill_memory();
        read_stimulus();
        loaded = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < n_tests; i++) begin
            run_access(i);
        end
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== src/dcache_cfg.svh ====
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// cache geometry
`define DCACHE_SETS        8
`define DCACHE_WAYS        2
`define DCACHE_LINE_BYTES  64

// core and memory bus widths
`define DCACHE_ADDR_W      16
`define DCACHE_WORD_W      32
`define DCACHE_BEAT_BYTES  16

`endif

// ==== src/dcache_ctrl.sv ====
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,
    input  logic                  req_write,
    input  dcache_pkg::addr_t     req_addr,
    input  dcache_pkg::dtype_t    req_dtype,
    input  dcache_pkg::word_t     req_wdata,
    output logic                  req_ready,
    output logic                  rsp_valid,
    input  logic                  hit,
    input  dcache_pkg::way_t      hit_way,
    input  dcache_pkg::way_t      victim_way,
    input  logic                  victim_dirty,
    input  dcache_pkg::tag_t      victim_tag,
    output logic                  lookup_en,
    output logic                  touch_en,
    output dcache_pkg::way_t      touch_way,
    output dcache_pkg::addr_t     touch_addr,
    output logic                  fill_en,
    output dcache_pkg::beat_idx_t fill_beat,
    output logic                  fill_last,
    output dcache_pkg::way_t      fill_way,
    output dcache_pkg::addr_t     fill_addr,
    output logic                  store_en,
    output dcache_pkg::way_t      store_way,
    output dcache_pkg::addr_t     store_addr,
    output dcache_pkg::dtype_t    store_dtype,
    output dcache_pkg::word_t     store_wdata,
    output dcache_pkg::way_t      rd_way,
    output dcache_pkg::addr_t     rd_addr,
    output dcache_pkg::dtype_t    rd_dtype,
    output dcache_pkg::beat_idx_t wb_beat,
    output logic                  mem_rd_valid,
    output dcache_pkg::blk_addr_t mem_rd_addr,
    output logic                  mem_wr_valid,
    output dcache_pkg::blk_addr_t mem_wr_addr,
    input  logic                  mem_rsp_valid
);
    import dcache_pkg::*;

    cache_state_t state;
    cache_state_t state_nx;

    // request in its lookup cycle
    logic      rq_valid;
    logic      rq_write;
    addr_t     rq_addr;
    dtype_t    rq_dtype;
    word_t     rq_wdata;

    // request parked on a miss, its way is the victim way
    logic      pd_write;
    addr_t     pd_addr;
    dtype_t    pd_dtype;
    word_t     pd_wdata;
    way_t      pd_way;
    logic      pd_done;

    beat_idx_t rd_cnt;
    beat_idx_t rsp_cnt;
    beat_idx_t wb_cnt;
    logic      rd_sent;
    logic      accept;
    logic      miss;
    logic      hit_acc;
    logic      sel_pd;
    way_t      sel_way;
    addr_t     sel_addr;
    dtype_t    sel_dtype;

    assign miss      = rq_valid && !hit;
    assign hit_acc   = rq_valid && hit;
    assign req_ready = (state == cs_ready) && !miss && !pd_done;
    assign accept    = req_valid && req_ready;
    assign lookup_en = accept;
    assign rsp_valid = (hit_acc && !rq_write) || (pd_done && !pd_write);

    always_ff @(posedge clk) begin
        if (rst) begin
            rq_valid <= 1'b0;
        end else begin
            rq_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rq_write <= req_write;
            rq_addr  <= req_addr;
            rq_dtype <= req_dtype;
            rq_wdata <= req_wdata;
        end
        if (state == cs_ready && miss) begin
            pd_write <= rq_write;
            pd_addr  <= rq_addr;
            pd_dtype <= rq_dtype;
            pd_wdata <= rq_wdata;
            pd_way   <= victim_way;
        end
    end

    always_comb begin
        state_nx = state;
        case (state)
            cs_reset: state_nx = cs_ready;
            cs_ready: begin
                if (miss) begin
                    state_nx = victim_dirty ? cs_evict : cs_miss;
                end
            end
            cs_evict: begin
                if (wb_cnt == '1) begin
                    state_nx = cs_miss;
                end
            end
            cs_miss: begin
                if (fill_last) begin
                    state_nx = cs_ready;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= cs_reset;
            pd_done <= 1'b0;
            rd_cnt  <= '0;
            rsp_cnt <= '0;
            wb_cnt  <= '0;
            rd_sent <= 1'b0;
        end else begin
            state   <= state_nx;
            // pending request is served in the first ready cycle
            pd_done <= fill_last;
            if (mem_wr_valid) begin
                wb_cnt <= wb_cnt + 1'b1;
            end
            if (mem_rd_valid) begin
                rd_cnt <= rd_cnt + 1'b1;
                if (rd_cnt == '1) begin
                    rd_sent <= 1'b1;
                end
            end
            if (fill_en) begin
                rsp_cnt <= rsp_cnt + 1'b1;
            end
            if (fill_last) begin
                rd_sent <= 1'b0;
            end
        end
    end

    // memory side, line beats go out from beat 0 upward
    assign mem_wr_valid = (state == cs_evict);
    assign mem_wr_addr  = {victim_tag, addr_set(pd_addr), wb_cnt};
    assign wb_beat      = wb_cnt;
    assign mem_rd_valid = (state == cs_miss) && !rd_sent;
    assign mem_rd_addr  = {addr_tag(pd_addr), addr_set(pd_addr), rd_cnt};

    assign fill_en   = (state == cs_miss) && mem_rsp_valid;
    assign fill_beat = rsp_cnt;
    assign fill_last = fill_en && (rsp_cnt == '1);
    assign fill_way  = pd_way;
    assign fill_addr = pd_addr;

    // outside plain ready operation the stores work on the pending request
    assign sel_pd    = (state != cs_ready) || pd_done;
    assign sel_way   = sel_pd ? pd_way : hit_way;
    assign sel_addr  = sel_pd ? pd_addr : rq_addr;
    assign sel_dtype = sel_pd ? pd_dtype : rq_dtype;

    assign touch_en    = hit_acc || pd_done;
    assign touch_way   = sel_way;
    assign touch_addr  = sel_addr;
    assign store_en    = (hit_acc && rq_write) || (pd_done && pd_write);
    assign store_way   = sel_way;
    assign store_addr  = sel_addr;
    assign store_dtype = sel_dtype;
    assign store_wdata = sel_pd ? pd_wdata : rq_wdata;
    assign rd_way      = sel_way;
    assign rd_addr     = sel_addr;
    assign rd_dtype    = sel_dtype;

endmodule

// ==== src/dcache_line_store.sv ====
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_line_store (
    input  logic                  clk,
    input  logic                  fill_en,
    input  dcache_pkg::beat_idx_t fill_beat,
    input  dcache_pkg::way_t      fill_way,
    input  dcache_pkg::addr_t     fill_addr,
    input  dcache_pkg::beat_t     mem_rsp_data,
    input  logic                  store_en,
    input  dcache_pkg::way_t      store_way,
    input  dcache_pkg::addr_t     store_addr,
    input  dcache_pkg::dtype_t    store_dtype,
    input  dcache_pkg::word_t     store_wdata,
    input  dcache_pkg::way_t      rd_way,
    input  dcache_pkg::addr_t     rd_addr,
    output dcache_pkg::word_t     rd_word,
    input  dcache_pkg::beat_idx_t wb_beat,
    input  dcache_pkg::way_t      victim_way,
    output dcache_pkg::beat_t     mem_wr_data
);
    import dcache_pkg::*;

    localparam int SETS  = `DCACHE_SETS;
    localparam int WAYS  = `DCACHE_WAYS;
    localparam int BEATS = `DCACHE_LINE_BYTES / `DCACHE_BEAT_BYTES;
    localparam int WB    = `DCACHE_WORD_W / 8;
    localparam int WPB   = `DCACHE_BEAT_BYTES / WB;
    localparam int BO_W  = $clog2(WB);
    localparam int WO_W  = $clog2(WPB);
    localparam int BT_LO = $clog2(`DCACHE_BEAT_BYTES);

    beat_t line_q [WAYS][SETS][BEATS];

    logic [WB-1:0]   st_size;
    logic [WB-1:0]   st_mask;
    word_t           st_data;
    set_t            st_set;
    beat_idx_t       st_beat;
    logic [WO_W-1:0] st_word;
    beat_idx_t       rd_beat;
    logic [WO_W-1:0] rd_wsel;

    always_comb begin
        case (store_dtype)
            dt_byte, dt_byte_u: st_size = WB'(1);
            dt_half, dt_half_u: st_size = WB'(3);
            default:            st_size = '1;
        endcase
    end

    // shift mask and data up to the byte lane of the address
    assign st_mask = st_size << store_addr[BO_W-1:0];
    assign st_data = store_wdata << (8 * store_addr[BO_W-1:0]);
    assign st_set  = addr_set(store_addr);
    assign st_beat = store_addr[BT_LO +: $bits(beat_idx_t)];
    assign st_word = store_addr[BO_W +: WO_W];

    always_ff @(posedge clk) begin
        if (fill_en) begin
            line_q[fill_way][addr_set(fill_addr)][fill_beat] <= mem_rsp_data;
        end
        if (store_en) begin
            for (int i = 0; i < WB; i++) begin
                if (st_mask[i]) begin
                    line_q[store_way][st_set][st_beat][(st_word * WB + i) * 8 +: 8]
                        <= st_data[i * 8 +: 8];
                end
            end
        end
    end

    assign rd_beat = rd_addr[BT_LO +: $bits(beat_idx_t)];
    assign rd_wsel = rd_addr[BO_W +: WO_W];
    assign rd_word = line_q[rd_way][addr_set(rd_addr)][rd_beat][rd_wsel * `DCACHE_WORD_W +:
                                                                `DCACHE_WORD_W];

    // victim set comes from the pending request address
    assign mem_wr_data = line_q[victim_way][st_set][wb_beat];

endmodule

// ==== src/dcache_load_align.sv ====
`timescale 1ns/1ps

module dcache_load_align (
    input  dcache_pkg::word_t  rd_word,
    input  logic [1:0]         rd_offset,
    input  dcache_pkg::dtype_t rd_dtype,
    output dcache_pkg::word_t  rsp_data
);
    import dcache_pkg::*;

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;
    logic        signed_ld;

    assign sel_byte  = rd_word[rd_offset * 8 +: 8];
    // halves are aligned, so only offset bit 1 matters
    assign sel_half  = rd_word[rd_offset[1] * 16 +: 16];
    assign signed_ld = !rd_dtype[2];

    always_comb begin
        case (rd_dtype)
            dt_byte, dt_byte_u: rsp_data = {{24{signed_ld & sel_byte[7]}}, sel_byte};
            dt_half, dt_half_u: rsp_data = {{16{signed_ld & sel_half[15]}}, sel_half};
            default:            rsp_data = rd_word;
        endcase
    end

endmodule

// ==== src/dcache_pkg.sv ====
`include "dcache_cfg.svh"

package dcache_pkg;

    typedef logic [`DCACHE_ADDR_W-1:0] addr_t;
    typedef logic [`DCACHE_WORD_W-1:0] word_t;
    typedef logic [`DCACHE_BEAT_BYTES*8-1:0] beat_t;
    // memory addresses count whole beats
    typedef logic [`DCACHE_ADDR_W-$clog2(`DCACHE_BEAT_BYTES)-1:0] blk_addr_t;
    typedef logic [$clog2(`DCACHE_SETS)-1:0] set_t;
    typedef logic [`DCACHE_ADDR_W-$clog2(`DCACHE_LINE_BYTES)
                   -$clog2(`DCACHE_SETS)-1:0] tag_t;
    typedef logic [$clog2(`DCACHE_WAYS)-1:0] way_t;
    typedef logic [$clog2(`DCACHE_LINE_BYTES/`DCACHE_BEAT_BYTES)-1:0] beat_idx_t;

    // bit 2 set selects zero extension on loads
    typedef enum logic [2:0] {
        dt_byte   = 3'b000,
        dt_half   = 3'b001,
        dt_word   = 3'b010,
        dt_byte_u = 3'b100,
        dt_half_u = 3'b101
    } dtype_t;

    typedef enum logic [1:0] {
        cs_reset,
        cs_ready,
        cs_miss,
        cs_evict
    } cache_state_t;

    function automatic set_t addr_set(input addr_t a);
        return a[$clog2(`DCACHE_LINE_BYTES) +: $bits(set_t)];
    endfunction

    function automatic tag_t addr_tag(input addr_t a);
        return a[`DCACHE_ADDR_W-1 -: $bits(tag_t)];
    endfunction

endpackage

// ==== src/dcache_tag_store.sv ====
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_tag_store (
    input  logic              clk,
    input  logic              rst,
    input  logic              lookup_en,
    input  dcache_pkg::addr_t req_addr,
    output logic              hit,
    output dcache_pkg::way_t  hit_way,
    output dcache_pkg::way_t  victim_way,
    output logic              victim_dirty,
    output dcache_pkg::tag_t  victim_tag,
    input  logic              touch_en,
    input  dcache_pkg::way_t  touch_way,
    input  dcache_pkg::addr_t touch_addr,
    input  logic              fill_last,
    input  dcache_pkg::way_t  fill_way,
    input  dcache_pkg::addr_t fill_addr,
    input  logic              store_en,
    input  dcache_pkg::way_t  store_way,
    input  dcache_pkg::addr_t store_addr
);
    import dcache_pkg::*;

    localparam int SETS = `DCACHE_SETS;
    localparam int WAYS = `DCACHE_WAYS;

    logic valid_q [SETS][WAYS];
    logic dirty_q [SETS][WAYS];
    tag_t tag_q   [SETS][WAYS];
    way_t lru_q   [SETS][WAYS];

    set_t lk_set;
    set_t tch_set;
    way_t lru_tch [WAYS];
    logic lk_hit;
    way_t lk_hit_way;
    way_t lk_victim;

    assign lk_set  = addr_set(req_addr);
    assign tch_set = addr_set(touch_addr);

    // counts of the touched set after this cycle's update
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            if (way_t'(w) == touch_way) begin
                lru_tch[w] = '0;
            end else if (lru_q[tch_set][w] < lru_q[tch_set][touch_way]) begin
                lru_tch[w] = lru_q[tch_set][w] + 1'b1;
            end else begin
                lru_tch[w] = lru_q[tch_set][w];
            end
        end
    end

    // a hit touching the same set this cycle must steer the victim choice
    always_comb begin
        way_t cnt;
        lk_hit     = 1'b0;
        lk_hit_way = '0;
        lk_victim  = '0;
        for (int w = 0; w < WAYS; w++) begin
            cnt = (touch_en && tch_set == lk_set) ? lru_tch[w] : lru_q[lk_set][w];
            if (valid_q[lk_set][w] && tag_q[lk_set][w] == addr_tag(req_addr)) begin
                lk_hit     = 1'b1;
                lk_hit_way = way_t'(w);
            end
            if (cnt == way_t'(WAYS - 1)) begin
                lk_victim = way_t'(w);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hit <= 1'b0;
        end else if (lookup_en) begin
            hit <= lk_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_en) begin
            hit_way      <= lk_hit_way;
            victim_way   <= lk_victim;
            victim_dirty <= dirty_q[lk_set][lk_victim];
            victim_tag   <= tag_q[lk_set][lk_victim];
        end
        if (fill_last) begin
            tag_q[addr_set(fill_addr)][fill_way] <= addr_tag(fill_addr);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < WAYS; w++) begin
                    valid_q[s][w] <= 1'b0;
                    dirty_q[s][w] <= 1'b0;
                    lru_q[s][w]   <= way_t'(w);
                end
            end
        end else begin
            if (touch_en) begin
                for (int w = 0; w < WAYS; w++) begin
                    lru_q[tch_set][w] <= lru_tch[w];
                end
            end
            if (fill_last) begin
                valid_q[addr_set(fill_addr)][fill_way] <= 1'b1;
                dirty_q[addr_set(fill_addr)][fill_way] <= 1'b0;
            end
            if (store_en) begin
                dirty_q[addr_set(store_addr)][store_way] <= 1'b1;
            end
        end
    end

endmodule

// ==== src/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,
    input  logic                  req_write,
    input  dcache_pkg::addr_t     req_addr,
    input  dcache_pkg::dtype_t    req_dtype,
    input  dcache_pkg::word_t     req_wdata,
    output logic                  req_ready,
    output logic                  rsp_valid,
    output dcache_pkg::word_t     rsp_data,
    output logic                  mem_rd_valid,
    output dcache_pkg::blk_addr_t mem_rd_addr,
    input  logic                  mem_rsp_valid,
    input  dcache_pkg::beat_t     mem_rsp_data,
    output logic                  mem_wr_valid,
    output dcache_pkg::blk_addr_t mem_wr_addr,
    output dcache_pkg::beat_t     mem_wr_data
);
    import dcache_pkg::*;

    logic      lookup_en;
    logic      hit;
    way_t      hit_way;
    way_t      victim_way;
    logic      victim_dirty;
    tag_t      victim_tag;
    logic      touch_en;
    way_t      touch_way;
    addr_t     touch_addr;
    logic      fill_en;
    beat_idx_t fill_beat;
    logic      fill_last;
    way_t      fill_way;
    addr_t     fill_addr;
    logic      store_en;
    way_t      store_way;
    addr_t     store_addr;
    dtype_t    store_dtype;
    word_t     store_wdata;
    way_t      rd_way;
    addr_t     rd_addr;
    dtype_t    rd_dtype;
    word_t     rd_word;
    beat_idx_t wb_beat;

    dcache_ctrl dcache_ctrl_i (
        .clk, .rst,
        .req_valid, .req_write, .req_addr, .req_dtype, .req_wdata,
        .req_ready, .rsp_valid,
        .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag,
        .lookup_en,
        .touch_en, .touch_way, .touch_addr,
        .fill_en, .fill_beat, .fill_last, .fill_way, .fill_addr,
        .store_en, .store_way, .store_addr, .store_dtype, .store_wdata,
        .rd_way, .rd_addr, .rd_dtype,
        .wb_beat,
        .mem_rd_valid, .mem_rd_addr, .mem_wr_valid, .mem_wr_addr,
        .mem_rsp_valid
    );

    dcache_tag_store dcache_tag_store_i (
        .clk, .rst,
        .lookup_en, .req_addr,
        .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag,
        .touch_en, .touch_way, .touch_addr,
        .fill_last, .fill_way, .fill_addr,
        .store_en, .store_way, .store_addr
    );

    dcache_line_store dcache_line_store_i (
        .clk,
        .fill_en, .fill_beat, .fill_way, .fill_addr, .mem_rsp_data,
        .store_en, .store_way, .store_addr, .store_dtype, .store_wdata,
        .rd_way, .rd_addr, .rd_word,
        .wb_beat, .victim_way, .mem_wr_data
    );

    dcache_load_align dcache_load_align_i (
        .rd_word   (rd_word),
        .rd_offset (rd_addr[1:0]),
        .rd_dtype  (rd_dtype),
        .rsp_data  (rsp_data)
    );

endmodule
